/* compile.f */
rtl/rv_pkg.sv
rtl/rv_regfile.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/rv_pc_unit.sv
rtl/rv_core.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_rv_core.sv

/* rtl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t op,
  output rv_pkg::word_t   result
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // only the low five bits count for every shift
  assign shamt = b[4:0];

  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb
  begin
    case (op)
      rv_pkg::ALU_ADD:
      begin
        result = a + b;
      end
      rv_pkg::ALU_SUB:
      begin
        result = a - b;
      end
      rv_pkg::ALU_SLL:
      begin
        result = a << shamt;
      end
      rv_pkg::ALU_SLT:
      begin
        result = {31'd0, lt_signed};
      end
      rv_pkg::ALU_SLTU:
      begin
        result = {31'd0, lt_unsigned};
      end
      rv_pkg::ALU_XOR:
      begin
        result = a ^ b;
      end
      rv_pkg::ALU_SRL:
      begin
        result = a >> shamt;
      end
      rv_pkg::ALU_SRA:
      begin
        // sign bit fills from the left
        result = $signed(a) >>> shamt;
      end
      rv_pkg::ALU_OR:
      begin
        result = a | b;
      end
      rv_pkg::ALU_AND:
      begin
        result = a & b;
      end
      default:
      begin
        result = '0;
      end
    endcase
  end

endmodule

/* rtl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t insn,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  output logic [3:0]    dmem_we,
  output logic          halt
);

  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t    imm;
  rv_pkg::word_t    branch_imm;
  rv_pkg::alu_op_t  alu_op;
  logic             use_imm;
  logic             rf_we;
  logic             is_branch;
  logic             is_store;
  logic             is_lui;
  logic [2:0]       branch_f3;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_b;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    rd_data;

  rv_decoder u_decoder (
    .insn       (insn),
    .rs1        (rs1),
    .rs2        (rs2),
    .rd         (rd),
    .imm        (imm),
    .branch_imm (branch_imm),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .rf_we      (rf_we),
    .is_branch  (is_branch),
    .is_store   (is_store),
    .is_lui     (is_lui),
    .halt       (halt),
    .branch_f3  (branch_f3)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (rf_we),
    .rd       (rd),
    .rd_data  (rd_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // second operand is the immediate for reg-imm and stores
  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu u_alu (
    .a      (rs1_data),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result)
  );

  // lui bypasses the alu
  assign rd_data = is_lui ? imm : alu_result;

  rv_pc_unit u_pc_unit (
    .clk        (clk),
    .rst        (rst),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .branch_imm (branch_imm),
    .is_branch  (is_branch),
    .halt       (halt),
    .branch_f3  (branch_f3),
    .pc         (pc)
  );

  // sw address is rs1 plus the S immediate
  assign dmem_addr  = alu_result;
  assign dmem_wdata = rs2_data;
  assign dmem_we    = is_store ? 4'b1111 : 4'b0000;

endmodule

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::insn_t    insn,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::word_t    imm,
  output rv_pkg::word_t    branch_imm,
  output rv_pkg::alu_op_t  alu_op,
  output logic             use_imm,
  output logic             rf_we,
  output logic             is_branch,
  output logic             is_store,
  output logic             is_lui,
  output logic             halt,
  output logic [2:0]       branch_f3
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = insn.r.opcode;
  assign funct3 = insn.r.funct3;
  assign funct7 = insn.r.funct7;

  // register fields sit in the same place in every format that has them
  assign rs1 = insn.r.rs1;
  assign rs2 = insn.r.rs2;
  assign rd  = insn.r.rd;

  assign branch_f3  = insn.b.funct3;
  assign branch_imm = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
                       insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};

  // operand immediate, S for stores, U for lui, I for the rest
  always_comb
  begin
    case (opcode)
      rv_pkg::OP_LUI:   imm = {insn.u.imm, 12'd0};
      rv_pkg::OP_STORE: imm = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
      default:          imm = {{20{insn.i.imm[11]}}, insn.i.imm};
    endcase
  end

  always_comb
  begin
    alu_op    = rv_pkg::ALU_ADD;
    use_imm   = 1'b0;
    rf_we     = 1'b0;
    is_branch = 1'b0;
    is_store  = 1'b0;
    is_lui    = 1'b0;
    halt      = 1'b0;

    case (opcode)
      rv_pkg::OP_LUI:
      begin
        is_lui = 1'b1;
        rf_we  = 1'b1;
      end
      rv_pkg::OP_REG_IMM, rv_pkg::OP_REG_REG:
      begin
        use_imm = (opcode == rv_pkg::OP_REG_IMM);
        rf_we   = 1'b1;
        case (funct3)
          rv_pkg::F3_ADD_SUB: alu_op = rv_pkg::ALU_ADD;
          rv_pkg::F3_SLL:     alu_op = rv_pkg::ALU_SLL;
          rv_pkg::F3_SLT:     alu_op = rv_pkg::ALU_SLT;
          rv_pkg::F3_SLTU:    alu_op = rv_pkg::ALU_SLTU;
          rv_pkg::F3_XOR:     alu_op = rv_pkg::ALU_XOR;
          rv_pkg::F3_SRL_SRA: alu_op = (funct7 == rv_pkg::F7_ALT) ? rv_pkg::ALU_SRA
                                                                   : rv_pkg::ALU_SRL;
          rv_pkg::F3_OR:      alu_op = rv_pkg::ALU_OR;
          default:            alu_op = rv_pkg::ALU_AND;
        endcase
        // sub only exists register-register
        if (!use_imm && funct3 == rv_pkg::F3_ADD_SUB && funct7 == rv_pkg::F7_ALT)
          alu_op = rv_pkg::ALU_SUB;
        // funct7 must be base, or alt where it picks sub/sra
        if ((!use_imm || funct3 == rv_pkg::F3_SLL || funct3 == rv_pkg::F3_SRL_SRA) &&
            funct7 != rv_pkg::F7_BASE &&
            !(funct7 == rv_pkg::F7_ALT &&
              (funct3 == rv_pkg::F3_SRL_SRA || (!use_imm && funct3 == rv_pkg::F3_ADD_SUB))))
          rf_we = 1'b0;
      end
      rv_pkg::OP_BRANCH:
      begin
        // funct3 010 and 011 are not branches
        is_branch = (funct3[2:1] != 2'b01);
      end
      rv_pkg::OP_STORE:
      begin
        use_imm  = 1'b1;
        is_store = (funct3 == rv_pkg::F3_SW);
      end
      rv_pkg::OP_ENVIRON:
      begin
        halt = (insn.i.imm == '0) && (insn.i.rs1 == '0) && (funct3 == '0) && (rd == '0);
      end
      default:
      begin
        rf_we = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/rv_pc_unit.sv */
`timescale 1ns/1ps

module rv_pc_unit (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t branch_imm,
  input  logic          is_branch,
  input  logic          halt,
  input  logic [2:0]    branch_f3,
  output rv_pkg::word_t pc
);

  logic          taken;
  rv_pkg::word_t pc_next;

  // branch condition on the two source registers
  always_comb
  begin
    case (branch_f3)
      rv_pkg::F3_BEQ:  taken = (rs1_data == rs2_data);
      rv_pkg::F3_BNE:  taken = (rs1_data != rs2_data);
      rv_pkg::F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      rv_pkg::F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      rv_pkg::F3_BLTU: taken = (rs1_data < rs2_data);
      rv_pkg::F3_BGEU: taken = (rs1_data >= rs2_data);
      default:         taken = 1'b0;
    endcase
  end

  assign pc_next = (is_branch && taken) ? pc + branch_imm : pc + rv_pkg::PC_STEP;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc <= '0;
    end
    else if (!halt)
    begin
      // ecall parks the core on its own address
      pc <= pc_next;
    end
  end

endmodule

/* rtl/rv_pkg.sv */
package rv_pkg;

  // datapath and register file sizes
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_idx_t;

  // byte distance between consecutive instructions
  localparam word_t PC_STEP = 32'd4;

  // major opcodes of the supported subset
  localparam logic [6:0] OP_LUI     = 7'b01_101_11;
  localparam logic [6:0] OP_REG_IMM = 7'b00_100_11;
  localparam logic [6:0] OP_REG_REG = 7'b01_100_11;
  localparam logic [6:0] OP_BRANCH  = 7'b11_000_11;
  localparam logic [6:0] OP_STORE   = 7'b01_000_11;
  localparam logic [6:0] OP_ENVIRON = 7'b11_100_11;

  // funct3 for the alu group, shared by register-immediate and register-register
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 for branches
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // only word stores are kept
  localparam logic [2:0] F3_SW = 3'b010;

  // funct7, the alternate value selects sub and sra
  localparam logic [6:0] F7_BASE = 7'b000_0000;
  localparam logic [6:0] F7_ALT  = 7'b010_0000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // the instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } insn_r_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } insn_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } insn_s_t;

  // branch offset bits are scattered, bit 0 is implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } insn_b_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } insn_u_t;

  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_s_t s;
    insn_b_t b;
    insn_u_t u;
  } insn_t;

endpackage

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  // x0 has no storage
  rv_pkg::word_t regs [1:rv_pkg::NUM_REGS-1];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 1; i < rv_pkg::NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we && rd != '0)
    begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_core \
  -f compile.f --Mdir obj_dir -o tb_rv_core

./obj_dir/tb_rv_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTBENCH PASSED" sim.log
then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

/* test/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t insn,
  input  rv_pkg::word_t pc,
  input  rv_pkg::word_t dmem_addr,
  input  rv_pkg::word_t dmem_wdata,
  input  logic [3:0]    dmem_we,
  input  logic          halt,
  output int            error_count
);

  rv_pkg::word_t model_regs [0:rv_pkg::NUM_REGS-1];
  rv_pkg::word_t model_pc;
  int            errors = 0;

  assign error_count = errors;

  task automatic compare(input string name, input rv_pkg::word_t exp, input rv_pkg::word_t got);
    if (got !== exp)
    begin
      errors++;
      $display("** Error: %s expected %08h got %08h at %0t", name, exp, got, $time);
    end
  endtask

  // alt picks sub for funct3 000 and the arithmetic shift for 101
  function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
    logic [4:0]    sh;
    rv_pkg::word_t r;
    sh = b[4:0];
    case (f3)
      rv_pkg::F3_ADD_SUB: r = alt ? a - b : a + b;
      rv_pkg::F3_SLL:     r = a << sh;
      rv_pkg::F3_SLT:     r = {31'd0, $signed(a) < $signed(b)};
      rv_pkg::F3_SLTU:    r = {31'd0, a < b};
      rv_pkg::F3_XOR:     r = a ^ b;
      rv_pkg::F3_SRL_SRA:
      begin
        if (alt)
          r = $signed(a) >>> sh;
        else
          r = a >> sh;
      end
      rv_pkg::F3_OR:      r = a | b;
      default:            r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::word_t a,
                                        input rv_pkg::word_t b);
    logic eq;
    logic lt_s;
    logic lt_u;
    eq   = (a == b);
    lt_s = ($signed(a) < $signed(b));
    lt_u = (a < b);
    case (f3)
      rv_pkg::F3_BEQ:  return eq;
      rv_pkg::F3_BNE:  return !eq;
      rv_pkg::F3_BLT:  return lt_s;
      rv_pkg::F3_BGE:  return !lt_s;
      rv_pkg::F3_BLTU: return lt_u;
      rv_pkg::F3_BGEU: return !lt_u;
      default:         return 1'b0;
    endcase
  endfunction

  always @(posedge clk)
  begin : model_step
    logic [6:0]    opcode;
    logic [2:0]    f3;
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t wb;
    logic          wb_en;
    logic          exp_store;
    logic          exp_halt;
    opcode    = insn[6:0];
    f3        = insn[14:12];
    a         = model_regs[insn[19:15]];
    b         = model_regs[insn[24:20]];
    imm_i     = {{20{insn[31]}}, insn[31:20]};
    imm_s     = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b     = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    exp_store = (opcode == rv_pkg::OP_STORE) && (f3 == rv_pkg::F3_SW);
    exp_halt  = (opcode == rv_pkg::OP_ENVIRON) && (insn[31:7] == '0);
    if (rst)
    begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++)
      begin
        model_regs[i] = '0;
      end
      model_pc = '0;
    end
    else
    begin
      compare("pc", model_pc, pc);
      compare("halt", {31'd0, exp_halt}, {31'd0, halt});
      compare("dmem_we", exp_store ? 32'h0000_000f : 32'h0, {28'd0, dmem_we});
      if (exp_store)
      begin
        compare("dmem_addr", a + imm_s, dmem_addr);
        compare("dmem_wdata", b, dmem_wdata);
      end
      wb_en = 1'b1;
      case (opcode)
        rv_pkg::OP_LUI:     wb = {insn[31:12], 12'h000};
        rv_pkg::OP_REG_IMM: wb = alu_ref(f3, (f3 == rv_pkg::F3_SRL_SRA) && insn[30], a, imm_i);
        rv_pkg::OP_REG_REG: wb = alu_ref(f3, insn[30], a, b);
        default:
        begin
          wb    = '0;
          wb_en = 1'b0;
        end
      endcase
      // ecall freezes the architectural state
      if (!exp_halt)
      begin
        if (wb_en && insn[11:7] != 5'd0)
          model_regs[insn[11:7]] = wb;
        if (opcode == rv_pkg::OP_BRANCH && branch_taken(f3, a, b))
          model_pc = model_pc + imm_b;
        else
          model_pc = model_pc + 32'd4;
      end
    end
  end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  input  logic reset_req,
  output logic clk,
  output logic rst
);

  logic clk_q = 1'b0;
  logic rst_q = 1'b1;
  logic req_q = 1'b0;
  logic hold  = 1'b1;

  // 8 ns period
  always #4 clk_q = ~clk_q;

  // request is captured on the rising edge, rst itself moves on the falling edge
  always @(posedge clk_q)
  begin
    req_q <= reset_req;
  end

  // rst stays high across two rising edges
  always @(negedge clk_q)
  begin
    if (req_q)
    begin
      rst_q <= 1'b1;
      hold  <= 1'b1;
    end
    else if (hold)
    begin
      hold <= 1'b0;
    end
    else
    begin
      rst_q <= 1'b0;
    end
  end

  assign clk = clk_q;
  assign rst = rst_q;

endmodule

/* test/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  localparam int            PROG_LEN      = 256;
  localparam int            NUM_PROGS     = 5;
  localparam int            HALT_TIMEOUT  = 2000;
  localparam int            HALT_HOLD     = 10;
  localparam int            RESET_TIMEOUT = 10;
  localparam int            SEED_BASE     = 32'h56d2_2a71;
  // addi x0, x0, 0 and ecall
  localparam rv_pkg::word_t NOP           = 32'h0000_0013;
  localparam rv_pkg::word_t ECALL         = 32'h0000_0073;

  logic          clk;
  logic          rst;
  logic          reset_req;
  rv_pkg::word_t insn;
  rv_pkg::word_t pc;
  rv_pkg::word_t dmem_addr;
  rv_pkg::word_t dmem_wdata;
  logic [3:0]    dmem_we;
  logic          halt;
  int            check_errors;
  int            seq_errors;
  int            seed;
  bit            aborted;
  rv_pkg::word_t prog_mem [0:PROG_LEN-1];

  tb_clock u_clock (.reset_req(reset_req), .clk(clk), .rst(rst));

  rv_core DUT (
    .clk        (clk),
    .rst        (rst),
    .insn       (insn),
    .pc         (pc),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .halt       (halt)
  );

  tb_checker u_checker (
    .clk         (clk),
    .rst         (rst),
    .insn        (insn),
    .pc          (pc),
    .dmem_addr   (dmem_addr),
    .dmem_wdata  (dmem_wdata),
    .dmem_we     (dmem_we),
    .halt        (halt),
    .error_count (check_errors)
  );

  // x0..x7 only, so operands collide and branches get taken
  function automatic rv_pkg::reg_idx_t rand_reg();
    rv_pkg::word_t w;
    w = $random(seed);
    return {2'b00, w[2:0]};
  endfunction

  task automatic build_program();
    rv_pkg::word_t    w;
    rv_pkg::word_t    kind;
    rv_pkg::reg_idx_t rd;
    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    logic [2:0]       f3;
    logic [2:0]       bf3;
    logic [6:0]       f7;
    logic [12:0]      off;
    // word 0 matches the nop that is on insn when reset drops
    prog_mem[0] = NOP;
    for (int i = 1; i < PROG_LEN; i++)
    begin
      w    = $random(seed);
      kind = $random(seed);
      rd   = rand_reg();
      rs1  = rand_reg();
      rs2  = rand_reg();
      f3   = w[14:12];
      f7   = (w[0] && (f3 == rv_pkg::F3_ADD_SUB || f3 == rv_pkg::F3_SRL_SRA)) ?
             rv_pkg::F7_ALT : rv_pkg::F7_BASE;
      // 010 and 011 are no branches, move them to bltu/bgeu
      bf3  = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
      off  = w[1] ? 13'd12 : 13'd8;
      if (i == PROG_LEN - 1)
        prog_mem[i] = ECALL;
      else if (i % 10 == 9)
        prog_mem[i] = {w[31:25], rs2, rs1, rv_pkg::F3_SW, w[11:7], rv_pkg::OP_STORE};
      else
      begin
        case (kind[2:0])
          3'd0:
            prog_mem[i] = {w[31:12], rd, rv_pkg::OP_LUI};
          3'd1, 3'd2, 3'd3:
          begin
            // shifts carry funct7 in the upper immediate bits
            if (f3 == rv_pkg::F3_SLL || f3 == rv_pkg::F3_SRL_SRA)
              prog_mem[i] = {f7, w[24:20], rs1, f3, rd, rv_pkg::OP_REG_IMM};
            else
              prog_mem[i] = {w[31:20], rs1, f3, rd, rv_pkg::OP_REG_IMM};
          end
          3'd4, 3'd5:
            prog_mem[i] = {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG_REG};
          default:
          begin
            if (w[2])
              rs2 = rs1;
            if (i < PROG_LEN - 4)
              prog_mem[i] = {off[12], off[10:5], rs2, rs1, bf3, off[4:1], off[11],
                             rv_pkg::OP_BRANCH};
            else
              prog_mem[i] = NOP;
          end
        endcase
      end
    end
  endtask

  task automatic drive_insn();
    rv_pkg::word_t idx;
    idx = pc >> 2;
    if (pc[1:0] != 2'b00 || idx >= PROG_LEN)
    begin
      seq_errors++;
      $display("instruction fetch at pc %08h lies outside the program (%0t)", pc, $time);
      insn = NOP;
    end
    else
    begin
      insn = prog_mem[idx[7:0]];
    end
  endtask

  task automatic request_reset();
    @(negedge clk);
    insn      = NOP;
    reset_req = 1'b1;
    @(negedge clk);
    reset_req = 1'b0;
  endtask

  task automatic wait_reset(output bit ok);
    int cycles;
    cycles = 0;
    do
    begin
      @(posedge clk);
      cycles++;
    end
    while (!rst && cycles < RESET_TIMEOUT);
    while (rst && cycles < RESET_TIMEOUT)
    begin
      @(posedge clk);
      cycles++;
    end
    ok = (cycles < RESET_TIMEOUT);
    if (!ok)
      $display("reset did not complete within %0d cycles", RESET_TIMEOUT);
  endtask

  task automatic run_program(input int prog);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < HALT_TIMEOUT)
    begin
      @(negedge clk);
      drive_insn();
      @(posedge clk);
      cycles++;
      seen = halt;
    end
    if (!seen)
    begin
      seq_errors++;
      aborted = 1'b1;
      $display("program %0d never raised halt within %0d cycles", prog, HALT_TIMEOUT);
    end
    else
    begin
      // the checker sees pc frozen and no stores here
      for (int i = 0; i < HALT_HOLD; i++)
      begin
        @(negedge clk);
        drive_insn();
        @(posedge clk);
      end
    end
  endtask

  initial
  begin : main
    bit ok;
    insn       = NOP;
    reset_req  = 1'b0;
    seq_errors = 0;
    aborted    = 1'b0;
    for (int p = 0; p < NUM_PROGS && !aborted; p++)
    begin
      seed = SEED_BASE + p;
      build_program();
      if (p != 0)
        request_reset();
      wait_reset(ok);
      if (!ok)
      begin
        seq_errors++;
        aborted = 1'b1;
      end
      else
      begin
        run_program(p);
      end
    end
    // let the checker finish the last compare
    @(negedge clk);
    $display("errors: %0d total, %0d from checker, %0d from sequencing",
             check_errors + seq_errors, check_errors, seq_errors);
    if (check_errors + seq_errors == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
